// File: source/secv_pkg.sv
// Core-wide types shared by the SEC-V function units
`default_nettype none

package secv_pkg;

    // Data path width, one machine word
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;

    // Function unit request from the issue stage
    typedef struct packed {
        logic  ena;     // Single-cycle strobe per instruction
        xlen_t src1;    // Operand 1, rs1 or zero-extended uimm
        xlen_t src2;    // Operand 2, CSR address in [11:0]
    } funit_in_t;

    // Function unit response back to the core
    typedef struct packed {
        logic  rdy;     // Result valid this cycle
        logic  err;     // Illegal instruction
        xlen_t res;     // Result for rd
    } funit_out_t;

    // Idle response, everything low
    function automatic funit_out_t funit_out_default();
        return '0;
    endfunction

    // Zicsr funct3 codes
    // 3'b000 and 3'b100 are not CSR operations
    typedef enum logic [2:0] {
        FUNCT3_CSR_RW  = 3'b001,
        FUNCT3_CSR_RS  = 3'b010,
        FUNCT3_CSR_RC  = 3'b011,
        FUNCT3_CSR_RWI = 3'b101,
        FUNCT3_CSR_RSI = 3'b110,
        FUNCT3_CSR_RCI = 3'b111
    } funct3_csr_t;

endpackage

`default_nettype wire

// File: source/csr_pkg.sv
// Machine-mode CSR addresses, trap cause types and register field layout
`default_nettype none

package csr_pkg;

    // 12-bit CSR address space
    typedef logic [11:0] csr_adr_t;

    // Machine information and trap setup
    localparam csr_adr_t CSR_MSTATUS  = 12'h300;
    localparam csr_adr_t CSR_MISA     = 12'h301;
    localparam csr_adr_t CSR_MIE      = 12'h304;
    localparam csr_adr_t CSR_MTVEC    = 12'h305;

    // Machine trap handling
    localparam csr_adr_t CSR_MSCRATCH = 12'h340;
    localparam csr_adr_t CSR_MEPC     = 12'h341;
    localparam csr_adr_t CSR_MCAUSE   = 12'h342;
    localparam csr_adr_t CSR_MTVAL    = 12'h343;
    localparam csr_adr_t CSR_MIP      = 12'h344;

    // Hart identification, read only
    localparam csr_adr_t CSR_MHARTID  = 12'hF14;

    // Synchronous exception code
    typedef logic [3:0] ex_cause_t;

    // Machine interrupt codes, also bit index into mip/mie
    typedef enum logic [3:0] {
        IRQ_CAUSE_MSI = 4'd3,
        IRQ_CAUSE_MTI = 4'd7,
        IRQ_CAUSE_MEI = 4'd11
    } irq_cause_t;

    // One bit per interrupt cause
    typedef logic [secv_pkg::XLEN-1:0] ivec_t;

    // mstatus fields
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;
    localparam int MSTATUS_MPP_HI = 12;

    // mtvec mode bit, 1 = vectored
    localparam int MTVEC_MODE = 0;

    // RV32I, MXL = 1 and extension I
    localparam secv_pkg::xlen_t MISA_VALUE = 32'h4000_0100;

    // MSI, MTI and MEI
    localparam ivec_t IRQ_MASK = 32'h0000_0888;

endpackage

`default_nettype wire

// File: source/csr_irq.sv
// Machine interrupt arbiter with fixed MEI, MSI, MTI priority
`timescale 1ns/100ps
`default_nettype none

module csr_irq (
    input  csr_pkg::ivec_t      irq_pend_i,
    input  logic                irq_ena_i,
    input  csr_pkg::ivec_t      irq_ena_vec_i,
    output logic                irq_req_o,
    output csr_pkg::irq_cause_t irq_cause_o
);
    import csr_pkg::*;

    // Pending, individually enabled and globally enabled
    ivec_t irq_act;

    assign irq_act = irq_ena_i ? (irq_pend_i & irq_ena_vec_i & IRQ_MASK) : '0;

    // Any live cause raises the request
    assign irq_req_o = |irq_act;

    // Fixed priority pick
    always_comb begin
        if (irq_act[IRQ_CAUSE_MEI]) begin
            irq_cause_o = IRQ_CAUSE_MEI;
        end else if (irq_act[IRQ_CAUSE_MSI]) begin
            irq_cause_o = IRQ_CAUSE_MSI;
        end else if (irq_act[IRQ_CAUSE_MTI]) begin
            irq_cause_o = IRQ_CAUSE_MTI;
        end else begin
            // Idle value
            irq_cause_o = IRQ_CAUSE_MEI;
        end
    end

endmodule

`default_nettype wire

// File: source/csr_regs.sv
// Machine-mode CSR file with trap capture, MRET restore and trap vector
`timescale 1ns/100ps
`default_nettype none

module csr_regs #(
    parameter int HART_ID = 0
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Access port from the function unit
    input  csr_pkg::csr_adr_t     csr_adr_i,
    input  logic                  csr_we_i,
    input  secv_pkg::xlen_t       csr_wdat_i,
    output secv_pkg::xlen_t       csr_rdat_o,

    // Trap events
    input  logic                  ex_i,
    input  csr_pkg::ex_cause_t    ex_cause_i,
    input  secv_pkg::xlen_t       trap_pc_i,
    input  secv_pkg::xlen_t       trap_adr_i,
    input  logic                  irq_ack_i,
    input  csr_pkg::irq_cause_t   irq_cause_i,
    input  logic                  mret_i,
    output secv_pkg::xlen_t       trap_vec_o,

    // Interrupt state
    input  csr_pkg::ivec_t        irq_pend_i,
    output logic                  irq_ena_o,
    output csr_pkg::ivec_t        irq_ena_vec_o
);
    import secv_pkg::*;
    import csr_pkg::*;

    // mtvec bit 1 and mepc bits 1:0 are hardwired zero
    localparam xlen_t MTVEC_WMASK = ~xlen_t'(2);
    localparam xlen_t MEPC_WMASK  = ~xlen_t'(3);

    // Machine registers
    logic  mstatus_mie_q;
    logic  mstatus_mpie_q;
    ivec_t mie_q;
    xlen_t mtvec_q;
    xlen_t mscratch_q;
    xlen_t mepc_q;
    xlen_t mcause_q;
    xlen_t mtval_q;

    // Local view of the arbiter request for vector offset
    logic  irq_req;
    xlen_t trap_base;

    // Register updates, trap events win over CSR writes
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mie_q          <= '0;
            mtvec_q        <= '0;
            mscratch_q     <= '0;
            mepc_q         <= '0;
            mcause_q       <= '0;
            mtval_q        <= '0;
        end else if (ex_i) begin
            mepc_q         <= trap_pc_i & MEPC_WMASK;
            mcause_q       <= {1'b0, {(XLEN-5){1'b0}}, ex_cause_i};
            mtval_q        <= trap_adr_i;
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
        end else if (irq_ack_i) begin
            // Interrupt entry, top bit of mcause marks it
            mepc_q         <= trap_pc_i & MEPC_WMASK;
            mcause_q       <= {1'b1, {(XLEN-5){1'b0}}, irq_cause_i};
            mtval_q        <= '0;
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
        end else if (mret_i) begin
            mstatus_mie_q  <= mstatus_mpie_q;
            mstatus_mpie_q <= 1'b1;
        end else if (csr_we_i) begin
            case (csr_adr_i)
                CSR_MSTATUS: begin
                    mstatus_mie_q  <= csr_wdat_i[MSTATUS_MIE];
                    mstatus_mpie_q <= csr_wdat_i[MSTATUS_MPIE];
                end
                CSR_MIE:      mie_q      <= csr_wdat_i & IRQ_MASK;
                CSR_MTVEC:    mtvec_q    <= csr_wdat_i & MTVEC_WMASK;
                CSR_MSCRATCH: mscratch_q <= csr_wdat_i;
                CSR_MEPC:     mepc_q     <= csr_wdat_i & MEPC_WMASK;
                CSR_MCAUSE:   mcause_q   <= csr_wdat_i;
                CSR_MTVAL:    mtval_q    <= csr_wdat_i;
                // misa, mhartid, mip and holes ignore writes
                default: ;
            endcase
        end
    end

    // Read mux, holes read zero
    always_comb begin
        csr_rdat_o = '0;
        case (csr_adr_i)
            CSR_MSTATUS: begin
                csr_rdat_o[MSTATUS_MIE]  = mstatus_mie_q;
                csr_rdat_o[MSTATUS_MPIE] = mstatus_mpie_q;
                // MPP fixed to machine mode
                csr_rdat_o[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = 2'b11;
            end
            CSR_MISA:     csr_rdat_o = MISA_VALUE;
            CSR_MIE:      csr_rdat_o = mie_q;
            CSR_MTVEC:    csr_rdat_o = mtvec_q;
            CSR_MSCRATCH: csr_rdat_o = mscratch_q;
            CSR_MEPC:     csr_rdat_o = mepc_q;
            CSR_MCAUSE:   csr_rdat_o = mcause_q;
            CSR_MTVAL:    csr_rdat_o = mtval_q;
            CSR_MIP:      csr_rdat_o = irq_pend_i & IRQ_MASK;
            CSR_MHARTID:  csr_rdat_o = xlen_t'(HART_ID);
            default:      csr_rdat_o = '0;
        endcase
    end

    // Same condition as the arbiter request
    assign irq_req = mstatus_mie_q & (|(irq_pend_i & mie_q));

    // Base is 4-byte aligned, offset only for vectored interrupts
    assign trap_base  = {mtvec_q[XLEN-1:2], 2'b00};
    assign trap_vec_o = (mtvec_q[MTVEC_MODE] && irq_req)
                      ? trap_base + {{(XLEN-6){1'b0}}, irq_cause_i, 2'b00}
                      : trap_base;

    assign irq_ena_o     = mstatus_mie_q;
    assign irq_ena_vec_o = mie_q;

endmodule

`default_nettype wire

// File: source/csr.sv
// Zicsr function unit, decodes the operation and forms the CSR write value
`timescale 1ns/100ps
`default_nettype none

module csr (
    // Function-unit clock and reset
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Issue side
    input  secv_pkg::funit_in_t   fu_i,
    output secv_pkg::funit_out_t  fu_o,
    input  secv_pkg::funct3_csr_t funct_i,
    input  logic                  rs1_zero_i,

    // Register file access
    output csr_pkg::csr_adr_t     csr_adr_o,
    output logic                  csr_we_o,
    output secv_pkg::xlen_t       csr_wdat_o,
    input  secv_pkg::xlen_t       csr_rdat_i
);
    import secv_pkg::*;

    always_comb begin
        fu_o       = funit_out_default();
        csr_adr_o  = '0;
        csr_we_o   = 1'b0;
        csr_wdat_o = '0;

        if (fu_i.ena) begin
            // Answer in the same cycle, no stall
            fu_o.rdy  = 1'b1;
            csr_adr_o = fu_i.src2[11:0];

            case (funct_i)
                FUNCT3_CSR_RW,
                FUNCT3_CSR_RWI: begin
                    fu_o.res   = csr_rdat_i;
                    csr_wdat_o = fu_i.src1;
                    csr_we_o   = 1'b1;
                end

                FUNCT3_CSR_RS,
                FUNCT3_CSR_RSI: begin
                    fu_o.res   = csr_rdat_i;
                    csr_wdat_o = csr_rdat_i | fu_i.src1;
                    // x0 or zero uimm, read only
                    csr_we_o   = !rs1_zero_i;
                end

                FUNCT3_CSR_RC,
                FUNCT3_CSR_RCI: begin
                    fu_o.res   = csr_rdat_i;
                    csr_wdat_o = csr_rdat_i & ~fu_i.src1;
                    // x0 or zero uimm, read only
                    csr_we_o   = !rs1_zero_i;
                end

                default: begin
                    // Illegal funct3, no write, result stays zero
                    fu_o.err = 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/csr_top.sv
// CSR subsystem top joining function unit, register file and interrupt arbiter
`timescale 1ns/100ps
`default_nettype none

module csr_top #(
    parameter int HART_ID = 0
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Function unit
    input  secv_pkg::funit_in_t   fu_i,
    output secv_pkg::funit_out_t  fu_o,
    input  secv_pkg::funct3_csr_t funct_i,
    input  logic                  rs1_zero_i,

    // Traps
    input  logic                  ex_i,
    input  csr_pkg::ex_cause_t    ex_cause_i,
    input  secv_pkg::xlen_t       trap_pc_i,
    input  secv_pkg::xlen_t       trap_adr_i,
    input  logic                  irq_ack_i,
    input  logic                  mret_i,
    output secv_pkg::xlen_t       trap_vec_o,

    // Interrupts
    input  csr_pkg::ivec_t        irq_pend_i,
    output logic                  irq_req_o,
    output csr_pkg::irq_cause_t   irq_cause_o
);
    import secv_pkg::*;
    import csr_pkg::*;

    // Function unit to register file
    csr_adr_t csr_adr;
    logic     csr_we;
    xlen_t    csr_wdat;
    xlen_t    csr_rdat;

    // Register file to arbiter
    logic     irq_ena;
    ivec_t    irq_ena_vec;

    csr u_csr (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .fu_i       (fu_i),
        .fu_o       (fu_o),
        .funct_i    (funct_i),
        .rs1_zero_i (rs1_zero_i),
        .csr_adr_o  (csr_adr),
        .csr_we_o   (csr_we),
        .csr_wdat_o (csr_wdat),
        .csr_rdat_i (csr_rdat)
    );

    csr_regs #(
        .HART_ID (HART_ID)
    ) u_csr_regs (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .csr_adr_i     (csr_adr),
        .csr_we_i      (csr_we),
        .csr_wdat_i    (csr_wdat),
        .csr_rdat_o    (csr_rdat),
        .ex_i          (ex_i),
        .ex_cause_i    (ex_cause_i),
        .trap_pc_i     (trap_pc_i),
        .trap_adr_i    (trap_adr_i),
        .irq_ack_i     (irq_ack_i),
        .irq_cause_i   (irq_cause_o),
        .mret_i        (mret_i),
        .trap_vec_o    (trap_vec_o),
        .irq_pend_i    (irq_pend_i),
        .irq_ena_o     (irq_ena),
        .irq_ena_vec_o (irq_ena_vec)
    );

    csr_irq u_csr_irq (
        .irq_pend_i    (irq_pend_i),
        .irq_ena_i     (irq_ena),
        .irq_ena_vec_i (irq_ena_vec),
        .irq_req_o     (irq_req_o),
        .irq_cause_o   (irq_cause_o)
    );

endmodule

`default_nettype wire

// File: tb/csr_model.svh
// Reference model of the machine-mode CSR state, trap entry and interrupt selection
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// Architectural state as software sees it
logic  m_mie;
logic  m_mpie;
ivec_t m_mie_vec;
xlen_t m_mtvec;
xlen_t m_mscratch;
xlen_t m_mepc;
xlen_t m_mcause;
xlen_t m_mtval;

task automatic model_reset();
    m_mie      = 1'b0;
    m_mpie     = 1'b0;
    m_mie_vec  = '0;
    m_mtvec    = '0;
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_mtval    = '0;
endtask

// Six Zicsr codes, the other two are illegal
function automatic logic model_legal(input funct3_csr_t f);
    return f inside {FUNCT3_CSR_RW, FUNCT3_CSR_RS, FUNCT3_CSR_RC,
                     FUNCT3_CSR_RWI, FUNCT3_CSR_RSI, FUNCT3_CSR_RCI};
endfunction

// Expected read value, HART_ID comes from the including testbench
function automatic xlen_t model_read(input csr_adr_t adr, input ivec_t pend);
    xlen_t v;
    v = '0;
    case (adr)
        CSR_MSTATUS: begin
            // MPP always machine mode
            v = xlen_t'(3) << 11;
            v[MSTATUS_MIE]  = m_mie;
            v[MSTATUS_MPIE] = m_mpie;
        end
        CSR_MISA:     v = MISA_VALUE;
        CSR_MIE:      v = m_mie_vec;
        CSR_MTVEC:    v = m_mtvec;
        CSR_MSCRATCH: v = m_mscratch;
        CSR_MEPC:     v = m_mepc;
        CSR_MCAUSE:   v = m_mcause;
        CSR_MTVAL:    v = m_mtval;
        CSR_MIP:      v = pend & IRQ_MASK;
        CSR_MHARTID:  v = xlen_t'(HART_ID);
        default:      v = '0;
    endcase
    return v;
endfunction

// Enabled and pending, before the global enable
function automatic ivec_t model_active(input ivec_t pend);
    return pend & m_mie_vec & IRQ_MASK;
endfunction

function automatic logic model_irq_req(input ivec_t pend);
    return m_mie && (model_active(pend) != '0);
endfunction

// External first, then software, then timer
function automatic irq_cause_t model_irq_cause(input ivec_t pend);
    ivec_t act;
    // Global enable off leaves nothing to pick
    act = m_mie ? model_active(pend) : '0;
    if (act[11]) return IRQ_CAUSE_MEI;
    if (act[3]) return IRQ_CAUSE_MSI;
    if (act[7]) return IRQ_CAUSE_MTI;
    return IRQ_CAUSE_MEI;
endfunction

function automatic xlen_t model_trap_vec(input ivec_t pend);
    xlen_t base;
    base = m_mtvec & ~xlen_t'(3);
    // Offset only in vectored mode with a live request
    if (m_mtvec[0] && model_irq_req(pend)) begin
        return base + 4 * xlen_t'(model_irq_cause(pend));
    end
    return base;
endfunction

// Masked register write, read-only and missing CSRs drop it
task automatic model_write(input csr_adr_t adr, input xlen_t wdat);
    case (adr)
        CSR_MSTATUS: begin
            m_mie  = wdat[MSTATUS_MIE];
            m_mpie = wdat[MSTATUS_MPIE];
        end
        CSR_MIE:      m_mie_vec  = wdat & IRQ_MASK;
        CSR_MTVEC:    m_mtvec    = wdat & ~xlen_t'(2);
        CSR_MSCRATCH: m_mscratch = wdat;
        CSR_MEPC:     m_mepc     = wdat & ~xlen_t'(3);
        CSR_MCAUSE:   m_mcause   = wdat;
        CSR_MTVAL:    m_mtval    = wdat;
        default: ;
    endcase
endtask

// One clock edge: exception, interrupt accept, MRET, then CSR write
task automatic model_step(
    input funit_in_t   fu,
    input funct3_csr_t funct,
    input logic        rs1_zero,
    input logic        ex,
    input ex_cause_t   ex_cause,
    input xlen_t       pc,
    input xlen_t       tval,
    input logic        ack,
    input logic        mret,
    input ivec_t       pend
);
    irq_cause_t cause;
    csr_adr_t   adr;
    xlen_t      old;
    xlen_t      wdat;
    logic       we;
    cause = model_irq_cause(pend);
    adr   = fu.src2[11:0];
    old   = model_read(adr, pend);
    we    = 1'b0;
    wdat  = '0;
    if (fu.ena) begin
        case (funct)
            FUNCT3_CSR_RW, FUNCT3_CSR_RWI: begin
                we   = 1'b1;
                wdat = fu.src1;
            end
            FUNCT3_CSR_RS, FUNCT3_CSR_RSI: begin
                we   = !rs1_zero;
                wdat = old | fu.src1;
            end
            FUNCT3_CSR_RC, FUNCT3_CSR_RCI: begin
                we   = !rs1_zero;
                wdat = old & ~fu.src1;
            end
            default: ;
        endcase
    end
    if (ex) begin
        m_mepc   = pc & ~xlen_t'(3);
        m_mcause = xlen_t'(ex_cause);
        m_mtval  = tval;
        m_mpie   = m_mie;
        m_mie    = 1'b0;
    end else if (ack) begin
        m_mepc   = pc & ~xlen_t'(3);
        m_mcause = (xlen_t'(1) << (XLEN - 1)) | xlen_t'(cause);
        m_mtval  = '0;
        m_mpie   = m_mie;
        m_mie    = 1'b0;
    end else if (mret) begin
        m_mie  = m_mpie;
        m_mpie = 1'b1;
    end else if (we) begin
        model_write(adr, wdat);
    end
endtask

`endif

// File: tb/csr_tb.sv
// Testbench for the CSR subsystem, random traffic checked against a reference model
`timescale 1ns/100ps
`default_nettype none

module csr_tb;
    import secv_pkg::*;
    import csr_pkg::*;

    localparam int HART_ID      = 5;
    localparam int CLK_PERIOD   = 10;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 16;
    // Ready is due in the cycle of the strobe, no extra cycles allowed
    localparam int READY_LIMIT  = 0;
    localparam int NUM_OPS      = 2000;
    localparam int NUM_ADRS     = 12;

    // x^32 + x^22 + x^2 + x + 1, right-shift form
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic        clk_i;
    logic        rst_n_i;
    funit_in_t   fu_i;
    funit_out_t  fu_o;
    funct3_csr_t funct_i;
    logic        rs1_zero_i;
    logic        ex_i;
    ex_cause_t   ex_cause_i;
    xlen_t       trap_pc_i;
    xlen_t       trap_adr_i;
    logic        irq_ack_i;
    logic        mret_i;
    ivec_t       irq_pend_i;
    xlen_t       trap_vec_o;
    logic        irq_req_o;
    irq_cause_t  irq_cause_o;

    logic [31:0] lfsr_q;

    `include "csr_model.svh"

    csr_top #(
        .HART_ID (HART_ID)
    ) dut_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .fu_i        (fu_i),
        .fu_o        (fu_o),
        .funct_i     (funct_i),
        .rs1_zero_i  (rs1_zero_i),
        .ex_i        (ex_i),
        .ex_cause_i  (ex_cause_i),
        .trap_pc_i   (trap_pc_i),
        .trap_adr_i  (trap_adr_i),
        .irq_ack_i   (irq_ack_i),
        .mret_i      (mret_i),
        .trap_vec_o  (trap_vec_o),
        .irq_pend_i  (irq_pend_i),
        .irq_req_o   (irq_req_o),
        .irq_cause_o (irq_cause_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ LFSR_TAPS;
        return s >> 1;
    endfunction

    // One LFSR step per bit
    function automatic xlen_t rand_bits(input int n);
        xlen_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[XLEN-2:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Implemented CSRs followed by two holes
    function automatic csr_adr_t adr_table(input int idx);
        case (idx)
            0: return CSR_MSTATUS;
            1: return CSR_MISA;
            2: return CSR_MIE;
            3: return CSR_MTVEC;
            4: return CSR_MSCRATCH;
            5: return CSR_MEPC;
            6: return CSR_MCAUSE;
            7: return CSR_MTVAL;
            8: return CSR_MIP;
            9: return CSR_MHARTID;
            10: return 12'h302;
            default: return 12'hB00;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %0t %s expected %b actual %b", $time, name, exp, act));
        end
    endtask

    task automatic check_cause(input string name, input irq_cause_t exp,
                               input irq_cause_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %0t %s expected %0d actual %0d",
                                $time, name, exp, act));
        end
    endtask

    task automatic clear_inputs();
        fu_i       = '0;
        funct_i    = FUNCT3_CSR_RS;
        rs1_zero_i = 1'b0;
        ex_i       = 1'b0;
        ex_cause_i = '0;
        trap_pc_i  = '0;
        trap_adr_i = '0;
        irq_ack_i  = 1'b0;
        mret_i     = 1'b0;
        irq_pend_i = '0;
    endtask

    // Random access with trap events mixed in
    task automatic drive_random(output csr_adr_t adr);
        logic [2:0] code;
        adr        = adr_table(rand_bits(4) % NUM_ADRS);
        code       = 3'(rand_bits(3));
        fu_i.ena   = (rand_bits(3) != 0);
        fu_i.src1  = rand_bits(XLEN);
        fu_i.src2  = xlen_t'(adr);
        funct_i    = funct3_csr_t'(code);
        rs1_zero_i = (rand_bits(2) == 0);
        irq_pend_i = rand_bits(XLEN);
        ex_i       = (rand_bits(3) == 0);
        ex_cause_i = ex_cause_t'(rand_bits(4));
        trap_pc_i  = rand_bits(XLEN);
        trap_adr_i = rand_bits(XLEN);
        // Core only takes an interrupt that is requested
        irq_ack_i  = model_irq_req(irq_pend_i) && (rand_bits(2) == 0);
        mret_i     = (rand_bits(3) == 0);
    endtask

    // CSRRS with x0, random src1 must be ignored
    task automatic drive_readback(input csr_adr_t adr);
        fu_i.ena   = 1'b1;
        fu_i.src1  = rand_bits(XLEN);
        fu_i.src2  = xlen_t'(adr);
        funct_i    = FUNCT3_CSR_RS;
        rs1_zero_i = 1'b1;
        ex_i       = 1'b0;
        irq_ack_i  = 1'b0;
        mret_i     = 1'b0;
    endtask

    // Ready outside the allowed window stops the run
    task automatic wait_ready();
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (fu_o.rdy !== 1'b1) begin
            if (waited == READY_LIMIT) begin
                abort_run("CSR unit gave no ready within the cycle limit");
            end
            @(negedge clk_i);
            waited++;
        end
    endtask

    // Outputs sampled mid-cycle, inputs settled since the drive point
    task automatic check_outputs();
        logic  legal;
        xlen_t exp_res;
        legal = model_legal(funct_i);
        if (fu_i.ena) begin
            exp_res = legal ? model_read(fu_i.src2[11:0], irq_pend_i) : '0;
            check_flag("fu_o.err", !legal, fu_o.err);
            check_word("fu_o.res", exp_res, fu_o.res);
        end else begin
            check_flag("fu_o.rdy", 1'b0, fu_o.rdy);
            check_flag("fu_o.err", 1'b0, fu_o.err);
            check_word("fu_o.res", '0, fu_o.res);
        end
        check_flag("irq_req_o", model_irq_req(irq_pend_i), irq_req_o);
        check_cause("irq_cause_o", model_irq_cause(irq_pend_i), irq_cause_o);
        check_word("trap_vec_o", model_trap_vec(irq_pend_i), trap_vec_o);
    endtask

    // Check, clock edge, model update, back to the drive point
    task automatic run_cycle();
        if (fu_i.ena) begin
            wait_ready();
        end else begin
            @(negedge clk_i);
        end
        check_outputs();
        @(posedge clk_i);
        model_step(fu_i, funct_i, rs1_zero_i,
                   ex_i, ex_cause_i, trap_pc_i, trap_adr_i,
                   irq_ack_i, mret_i, irq_pend_i);
        #DRIVE_DELAY;
    endtask

    initial begin
        csr_adr_t adr;
        int       cnt;
        lfsr_q  = 32'd71865;
        clk_i   = 1'b0;
        rst_n_i = 1'b0;
        clear_inputs();
        model_reset();

        cnt = 0;
        while (cnt < RESET_CYCLES) begin
            @(posedge clk_i);
            cnt++;
        end
        #DRIVE_DELAY;
        rst_n_i = 1'b1;

        // Reset values of every address
        for (int i = 0; i < NUM_ADRS; i++) begin
            drive_readback(adr_table(i));
            run_cycle();
        end

        // Random op, then read back the same CSR
        for (int n = 0; n < NUM_OPS; n++) begin
            drive_random(adr);
            run_cycle();
            drive_readback(adr);
            run_cycle();
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+tb
source/secv_pkg.sv
source/csr_pkg.sv
source/csr_irq.sv
source/csr_regs.sv
source/csr.sv
source/csr_top.sv
tb/csr_tb.sv

// File: Bender.yml
package:
  name: secv_csr

sources:
  - source/secv_pkg.sv
  - source/csr_pkg.sv
  - source/csr_irq.sv
  - source/csr_regs.sv
  - source/csr.sv
  - source/csr_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/csr_tb.sv
